// ==== bench/dcache_golden.txt ====
# columns: we addr wdata size signed exp_rdata exp_exc (hex; size 0 byte, 1 half, 2 word)
# memory word at address a reads (a xor 5a5a0000) until written back
0 00001000 00000000 2 0 5a5a1000 0
0 00001004 00000000 2 0 5a5a1004 0
# byte and halfword loads, line 808080c0
0 808080c0 00000000 0 1 ffffffc0 0
0 808080c1 00000000 0 0 00000080 0
0 808080c2 00000000 0 1 ffffffda 0
0 808080c3 00000000 0 0 000000da 0
0 808080c1 00000000 0 1 ffffff80 0
0 808080c0 00000000 0 0 000000c0 0
0 808080c0 00000000 1 1 ffff80c0 0
0 808080c2 00000000 1 0 0000dada 0
0 808080c2 00000000 1 1 ffffdada 0
0 808080c4 00000000 1 0 000080c4 0
0 0000100a 00000000 0 1 0000005a 0
# stores on hit
1 00001001 000000a5 0 0 00000000 0
0 00001000 00000000 2 0 5a5aa500 0
1 0000100e 0000beef 1 0 00000000 0
0 0000100c 00000000 2 0 beef100c 0
# stores on miss
1 00002024 12345678 2 0 00000000 0
0 00002024 00000000 2 0 12345678 0
0 00002020 00000000 2 0 5a5a2020 0
1 0000303b 00000077 0 0 00000000 0
0 00003038 00000000 2 0 775a3038 0
# set 5 with three lines, two of them dirty
1 00004050 aaaa0001 2 0 00000000 0
1 00005054 bbbb0002 2 0 00000000 0
0 00006058 00000000 2 0 5a5a6058 0
0 00004050 00000000 2 0 aaaa0001 0
0 00005054 00000000 2 0 bbbb0002 0
0 00004054 00000000 2 0 5a5a4054 0
# misaligned accesses leave the cache unchanged
0 00001003 00000000 1 1 00000000 1
1 00001002 deadbeef 2 0 00000000 1
0 00001000 00000000 2 0 5a5aa500 0
1 00002025 00001111 1 0 00000000 1
0 00002024 00000000 2 0 12345678 0
0 00007071 00000000 2 0 00000000 1
0 00007070 00000000 2 0 5a5a7070 0
# word store hit, halfword store miss
1 00007074 cafef00d 2 0 00000000 0
0 00007074 00000000 2 0 cafef00d 0
1 00008082 00009abc 1 0 00000000 0
0 00008080 00000000 2 0 9abc8080 0

// ==== dcache.f ====
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_load_align.sv
design/dcache_ctrl.sv
design/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module dcache_tb -f dcache.f \
    --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "no pass line in $LOG"
exit 1

// ==== bench/dcache_tb.sv ====
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int    RESET_CYCLES      = 8;
    localparam int    CYCLES_PER_ACCESS = 60;
    localparam string GOLDEN_FILE       = "bench/dcache_golden.txt";

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  size;
        logic        sgn;
        logic [31:0] rdata;
        logic        exc;
    } access_t;

    logic              clk;
    logic              rstn;
    logic              i_req_valid;
    logic              o_req_ready;
    logic              i_req_we;
    logic [31:0]       i_req_addr;
    logic [31:0]       i_req_wdata;
    size_t             i_req_size;
    logic              i_req_signed;
    logic              o_resp_valid;
    logic              i_resp_ready = 1'b0;
    logic [31:0]       o_resp_rdata;
    logic              o_resp_exc;
    logic              o_mem_rd_valid;
    logic              i_mem_rd_ready;
    logic [31:0]       o_mem_rd_addr;
    logic [LINE_W-1:0] i_mem_rd_line;
    logic              o_mem_wr_valid;
    logic              i_mem_wr_ready;
    logic [31:0]       o_mem_wr_addr;
    logic [LINE_W-1:0] o_mem_wr_line;

    integer  seed = 32'hc274e75c;
    int      errors = 0;
    int      timeout_cycles = 0;
    int      current = 0;
    access_t accesses[$];

    dcache_top u_dut (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .o_req_ready    (o_req_ready),
        .i_req_we       (i_req_we),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .i_req_size     (i_req_size),
        .i_req_signed   (i_req_signed),
        .o_resp_valid   (o_resp_valid),
        .i_resp_ready   (i_resp_ready),
        .o_resp_rdata   (o_resp_rdata),
        .o_resp_exc     (o_resp_exc),
        .o_mem_rd_valid (o_mem_rd_valid),
        .i_mem_rd_ready (i_mem_rd_ready),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_line  (i_mem_rd_line),
        .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_wr_addr  (o_mem_wr_addr),
        .o_mem_wr_line  (o_mem_wr_line)
    );

    dcache_mem_model u_mem (
        .clk        (clk),
        .i_rd_valid (o_mem_rd_valid),
        .o_rd_ready (i_mem_rd_ready),
        .i_rd_addr  (o_mem_rd_addr),
        .o_rd_line  (i_mem_rd_line),
        .i_wr_valid (o_mem_wr_valid),
        .o_wr_ready (i_mem_wr_ready),
        .i_wr_addr  (o_mem_wr_addr),
        .i_wr_line  (o_mem_wr_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pipeline takes the response about three cycles in four
    always @(posedge clk) i_resp_ready <= (($random(seed) & 3) != 0);

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       text;
        access_t     acc;
        logic [31:0] f_we, f_addr, f_wdata, f_size, f_sgn, f_rdata, f_exc;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the golden file %s", GOLDEN_FILE);
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            n = $sscanf(text, "%h %h %h %h %h %h %h",
                        f_we, f_addr, f_wdata, f_size, f_sgn, f_rdata, f_exc);
            if (n == 7) begin   // comment and blank lines fall through
                acc.we    = f_we[0];
                acc.addr  = f_addr;
                acc.wdata = f_wdata;
                acc.size  = f_size[1:0];
                acc.sgn   = f_sgn[0];
                acc.rdata = f_rdata;
                acc.exc   = f_exc[0];
                accesses.push_back(acc);
            end
        end
        $fclose(fd);
        if (accesses.size() == 0) begin
            errors++;
            $display("the golden file holds no accesses");
        end
    endtask

    task automatic run_access(input int idx);
        access_t acc;
        logic [31:0] got_rdata;
        logic        got_exc;
        acc = accesses[idx];
        @(posedge clk);
        i_req_valid  <= 1'b1;
        i_req_we     <= acc.we;
        i_req_addr   <= acc.addr;
        i_req_wdata  <= acc.wdata;
        i_req_size   <= size_t'(acc.size);
        i_req_signed <= acc.sgn;
        do @(negedge clk); while (!o_req_ready);
        @(posedge clk);   // accepted on this edge
        i_req_valid <= 1'b0;
        do @(negedge clk); while (!(o_resp_valid && i_resp_ready));
        got_rdata = o_resp_rdata;
        got_exc   = o_resp_exc;
        check_value($sformatf("access %0d at %h rdata", idx, acc.addr), got_rdata, acc.rdata);
        check_value($sformatf("access %0d at %h exc", idx, acc.addr),
                    {31'd0, got_exc}, {31'd0, acc.exc});
    endtask

    initial begin
        int cycles;
        cycles = 0;
        wait (timeout_cycles != 0);
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, access %0d never finished", cycles, current);
        $display("test failed");
        $finish;
    end

    initial begin
        rstn         = 1'b0;
        i_req_valid  = 1'b0;
        i_req_we     = 1'b0;
        i_req_addr   = '0;
        i_req_wdata  = '0;
        i_req_size   = SIZE_BYTE;
        i_req_signed = 1'b0;
        load_golden();
        if (accesses.size() > 0)
            timeout_cycles = accesses.size() * CYCLES_PER_ACCESS + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        // ready high, every valid low
        check_value("outputs after reset",
                    {28'd0, o_req_ready, o_resp_valid, o_mem_rd_valid, o_mem_wr_valid},
                    32'h8);
        for (int i = 0; i < accesses.size(); i++) begin
            current = i;
            run_access(i);
        end
        $display("%0d errors in %0d accesses", errors, accesses.size());
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== bench/dcache_mem_model.sv ====
module dcache_mem_model (
    input  logic                          clk,
    input  logic                          i_rd_valid,
    output logic                          o_rd_ready,
    input  logic [dcache_pkg::ADDR_W-1:0] i_rd_addr,
    output logic [dcache_pkg::LINE_W-1:0] o_rd_line,
    input  logic                          i_wr_valid,
    output logic                          o_wr_ready,
    input  logic [dcache_pkg::ADDR_W-1:0] i_wr_addr,
    input  logic [dcache_pkg::LINE_W-1:0] i_wr_line
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam logic [ADDR_W-1:0] PATTERN = 32'h5a5a0000;

    integer            seed = 32'hc274e75c;
    logic              rd_ready = 1'b0;
    logic              wr_ready = 1'b0;
    logic [LINE_W-1:0] rd_line = '0;
    logic [LINE_W-1:0] lines [logic [ADDR_W-1:0]];   // written-back lines by line address

    function automatic logic [ADDR_W-1:0] line_base(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:BYTE_OFFSET_W], {BYTE_OFFSET_W{1'b0}}};
    endfunction

    // untouched words hold their own address xor the pattern
    function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        logic [LINE_W-1:0] line;
        base = line_base(addr);
        if (lines.exists(base)) begin
            line = lines[base];
        end else begin
            for (int w = 0; w < LINE_BYTES / 4; w++) begin
                line[w*32 +: 32] = (base + ADDR_W'(w * 4)) ^ PATTERN;
            end
        end
        return line;
    endfunction

    always @(posedge clk) begin
        // read ready only follows a pending read request
        rd_ready <= i_rd_valid && (($random(seed) & 3) != 0);
        wr_ready <= (($random(seed) & 3) != 0);   // about three cycles in four
        if (i_wr_valid && wr_ready)
            lines[line_base(i_wr_addr)] = i_wr_line;
        rd_line <= line_at(i_rd_addr);   // addr is stable from lookup on
    end

    assign o_rd_ready = rd_ready;
    assign o_wr_ready = wr_ready;
    assign o_rd_line  = rd_line;

endmodule

// ==== design/dcache_top.sv ====
module dcache_top (
    input  logic                             clk,
    input  logic                             rstn,
    // request from pipeline
    input  logic                             i_req_valid,
    output logic                             o_req_ready,
    input  logic                             i_req_we,
    input  logic [dcache_pkg::ADDR_W-1:0]    i_req_addr,
    input  logic [31:0]                      i_req_wdata,
    input  dcache_pkg::size_t                i_req_size,
    input  logic                             i_req_signed,
    // response to pipeline
    output logic                             o_resp_valid,
    input  logic                             i_resp_ready,
    output logic [31:0]                      o_resp_rdata,
    output logic                             o_resp_exc,
    // memory line read
    output logic                             o_mem_rd_valid,
    input  logic                             i_mem_rd_ready,
    output logic [dcache_pkg::ADDR_W-1:0]    o_mem_rd_addr,
    input  logic [dcache_pkg::LINE_W-1:0]    i_mem_rd_line,
    // memory line write
    output logic                             o_mem_wr_valid,
    input  logic                             i_mem_wr_ready,
    output logic [dcache_pkg::ADDR_W-1:0]    o_mem_wr_addr,
    output logic [dcache_pkg::LINE_W-1:0]    o_mem_wr_line
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0]                    rd_index;
    logic [INDEX_W-1:0]                    wr_index;
    logic [TAG_W-1:0]                      lookup_tag;
    logic [NUM_WAYS-1:0][LINE_BYTES-1:0]   way_byte_we;
    logic [LINE_W-1:0]                     way_wr_line;
    logic [NUM_WAYS-1:0]                   way_fill;
    logic [NUM_WAYS-1:0]                   way_set_dirty;
    logic [NUM_WAYS-1:0]                   way_hit;
    logic [NUM_WAYS-1:0][LINE_W-1:0]       way_line;
    logic [NUM_WAYS-1:0][TAG_W-1:0]        way_tag;
    logic [NUM_WAYS-1:0]                   way_valid;
    logic [NUM_WAYS-1:0]                   way_dirty;
    logic [BYTE_OFFSET_W-1:0]              addr_low;
    size_t                                 buf_size;
    logic                                  buf_signed;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .i_req_valid     (i_req_valid),
        .o_req_ready     (o_req_ready),
        .i_req_we        (i_req_we),
        .i_req_addr      (i_req_addr),
        .i_req_wdata     (i_req_wdata),
        .i_req_size      (i_req_size),
        .i_req_signed    (i_req_signed),
        .o_resp_valid    (o_resp_valid),
        .i_resp_ready    (i_resp_ready),
        .o_resp_exc      (o_resp_exc),
        .o_mem_rd_valid  (o_mem_rd_valid),
        .i_mem_rd_ready  (i_mem_rd_ready),
        .o_mem_rd_addr   (o_mem_rd_addr),
        .i_mem_rd_line   (i_mem_rd_line),
        .o_mem_wr_valid  (o_mem_wr_valid),
        .i_mem_wr_ready  (i_mem_wr_ready),
        .o_mem_wr_addr   (o_mem_wr_addr),
        .o_mem_wr_line   (o_mem_wr_line),
        .o_rd_index      (rd_index),
        .o_lookup_tag    (lookup_tag),
        .o_wr_index      (wr_index),
        .o_way_byte_we   (way_byte_we),
        .o_way_wr_line   (way_wr_line),
        .o_way_fill      (way_fill),
        .o_way_set_dirty (way_set_dirty),
        .i_way_hit       (way_hit),
        .i_way_tag       (way_tag),
        .i_way_valid     (way_valid),
        .i_way_dirty     (way_dirty),
        .i_way_line      (way_line),
        .o_addr_low      (addr_low),
        .o_size          (buf_size),
        .o_signed        (buf_signed)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk         (clk),
            .rstn        (rstn),
            .i_rd_index  (rd_index),
            .i_tag       (lookup_tag),
            .i_wr_index  (wr_index),
            .i_byte_we   (way_byte_we[w]),
            .i_wr_line   (way_wr_line),
            .i_fill      (way_fill[w]),
            .i_set_dirty (way_set_dirty[w]),
            .o_hit       (way_hit[w]),
            .o_line      (way_line[w]),
            .o_tag       (way_tag[w]),
            .o_valid     (way_valid[w]),
            .o_dirty     (way_dirty[w])
        );
    end

    dcache_load_align u_align (
        .i_way_hit  (way_hit),
        .i_way_line (way_line),
        .i_addr_low (addr_low),
        .i_size     (buf_size),
        .i_signed   (buf_signed),
        .o_rdata    (o_resp_rdata)
    );

endmodule

// ==== design/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                                                    clk,
    input  logic                                                    rstn,
    input  logic                                                    i_req_valid,
    output logic                                                    o_req_ready,
    input  logic                                                    i_req_we,
    input  logic [dcache_pkg::ADDR_W-1:0]                           i_req_addr,
    input  logic [31:0]                                             i_req_wdata,
    input  dcache_pkg::size_t                                       i_req_size,
    input  logic                                                    i_req_signed,
    output logic                                                    o_resp_valid,
    input  logic                                                    i_resp_ready,
    output logic                                                    o_resp_exc,
    output logic                                                    o_mem_rd_valid,
    input  logic                                                    i_mem_rd_ready,
    output logic [dcache_pkg::ADDR_W-1:0]                           o_mem_rd_addr,
    input  logic [dcache_pkg::LINE_W-1:0]                           i_mem_rd_line,
    output logic                                                    o_mem_wr_valid,
    input  logic                                                    i_mem_wr_ready,
    output logic [dcache_pkg::ADDR_W-1:0]                           o_mem_wr_addr,
    output logic [dcache_pkg::LINE_W-1:0]                           o_mem_wr_line,
    output logic [dcache_pkg::INDEX_W-1:0]                          o_rd_index,
    output logic [dcache_pkg::TAG_W-1:0]                            o_lookup_tag,
    output logic [dcache_pkg::INDEX_W-1:0]                          o_wr_index,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::LINE_BYTES-1:0] o_way_byte_we,
    output logic [dcache_pkg::LINE_W-1:0]                           o_way_wr_line,
    output logic [dcache_pkg::NUM_WAYS-1:0]                         o_way_fill,
    output logic [dcache_pkg::NUM_WAYS-1:0]                         o_way_set_dirty,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                         i_way_hit,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_W-1:0]  i_way_tag,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                         i_way_valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                         i_way_dirty,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::LINE_W-1:0] i_way_line,
    output logic [dcache_pkg::BYTE_OFFSET_W-1:0]                    o_addr_low,
    output dcache_pkg::size_t                                       o_size,
    output logic                                                    o_signed
);
    import dcache_pkg::*;

    state_t                 state;
    state_t                 next_state;
    logic [ADDR_W-1:0]      addr_q;        // request buffer
    logic [31:0]            wdata_q;
    logic                   we_q;
    size_t                  size_q;
    logic                   signed_q;
    logic [SET_NUM-1:0]     lru;           // way to replace next
    logic                   victim_q;
    logic [LINE_W-1:0]      refill_q;
    logic [INDEX_W-1:0]     index_q;
    logic [TAG_W-1:0]       tag_q;
    logic                   misaligned;
    logic                   any_hit;
    logic                   hit_way;
    logic                   lookup_victim;
    logic                   store_hit;
    logic [3:0]             strb_word;
    logic [LINE_BYTES-1:0]  strb_line;
    logic [LINE_W-1:0]      store_line;
    logic [LINE_W-1:0]      merged_line;

    assign index_q       = addr_q[BYTE_OFFSET_W +: INDEX_W];
    assign tag_q         = addr_q[ADDR_W-1 -: TAG_W];
    assign any_hit       = |i_way_hit;
    assign hit_way       = i_way_hit[1];
    assign lookup_victim = lru[index_q];
    assign store_hit     = (state == ST_LOOKUP) && !misaligned && any_hit && we_q;

    always_comb begin
        case (size_q)
            SIZE_HALF: misaligned = addr_q[0];
            SIZE_WORD: misaligned = |addr_q[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // store data and strobes moved to their place in the line
    always_comb begin
        case (size_q)
            SIZE_BYTE: strb_word = 4'b0001;
            SIZE_HALF: strb_word = 4'b0011;
            SIZE_WORD: strb_word = 4'b1111;
            default:   strb_word = 4'b0000;
        endcase
    end
    assign strb_line  = {{(LINE_BYTES-4){1'b0}}, strb_word} << addr_q[BYTE_OFFSET_W-1:0];
    assign store_line = {{(LINE_W-32){1'b0}}, wdata_q} << {addr_q[BYTE_OFFSET_W-1:0], 3'b000};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (we_q && strb_line[b])
                merged_line[b*8 +: 8] = store_line[b*8 +: 8];
            else
                merged_line[b*8 +: 8] = refill_q[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_ready && i_req_valid) begin
            addr_q   <= i_req_addr;
            wdata_q  <= i_req_wdata;
            we_q     <= i_req_we;
            size_q   <= i_req_size;
            signed_q <= i_req_signed;
        end
        if (state == ST_LOOKUP && !any_hit)
            victim_q <= lookup_victim;
        if (o_mem_rd_valid && i_mem_rd_ready)
            refill_q <= i_mem_rd_line;   // line only valid in handshake cycle
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (state == ST_LOOKUP && !misaligned && any_hit) begin
            lru[index_q] <= ~hit_way;
        end else if (state == ST_REFILL) begin
            lru[index_q] <= ~victim_q;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (i_req_valid)
                    next_state = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (misaligned || any_hit) begin
                    if (i_resp_ready)
                        next_state = ST_IDLE;
                end else if (i_way_valid[lookup_victim] && i_way_dirty[lookup_victim]) begin
                    next_state = ST_WRITEBACK;
                end else begin
                    next_state = ST_MISS;
                end
            end
            ST_WRITEBACK: if (i_mem_wr_ready) next_state = ST_MISS;
            ST_MISS:      if (i_mem_rd_ready) next_state = ST_REFILL;
            ST_REFILL:    next_state = ST_RESPOND;
            ST_RESPOND:   if (any_hit && i_resp_ready) next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    assign o_req_ready  = (state == ST_IDLE);
    assign o_resp_valid = ((state == ST_LOOKUP) && (misaligned || any_hit)) ||
                          ((state == ST_RESPOND) && any_hit);   // wait for the re-read to hit
    assign o_resp_exc   = (state == ST_LOOKUP) && misaligned;

    assign o_mem_rd_valid = (state == ST_MISS);
    assign o_mem_rd_addr  = {addr_q[ADDR_W-1:BYTE_OFFSET_W], {BYTE_OFFSET_W{1'b0}}};
    // victim set keeps being re-read, so payload holds steady
    assign o_mem_wr_valid = (state == ST_WRITEBACK);
    assign o_mem_wr_addr  = {i_way_tag[victim_q], index_q, {BYTE_OFFSET_W{1'b0}}};
    assign o_mem_wr_line  = i_way_line[victim_q];

    assign o_rd_index   = (state == ST_IDLE) ? i_req_addr[BYTE_OFFSET_W +: INDEX_W] : index_q;
    assign o_lookup_tag = tag_q;
    assign o_wr_index   = index_q;

    always_comb begin
        o_way_byte_we   = '0;
        o_way_fill      = '0;
        o_way_set_dirty = '0;
        if (store_hit) begin
            o_way_byte_we[hit_way]   = strb_line;
            o_way_set_dirty[hit_way] = 1'b1;
        end else if (state == ST_REFILL) begin
            o_way_byte_we[victim_q]   = '1;     // whole line
            o_way_fill[victim_q]      = 1'b1;
            o_way_set_dirty[victim_q] = we_q;
        end
    end
    assign o_way_wr_line = (state == ST_REFILL) ? merged_line : store_line;

    assign o_addr_low = addr_q[BYTE_OFFSET_W-1:0];
    assign o_signed   = signed_q;
    // unused size code makes the aligner return zero for stores and exceptions
    assign o_size     = (we_q || misaligned) ? size_t'(2'b11) : size_q;

endmodule

// ==== design/dcache_load_align.sv ====
module dcache_load_align (
    input  logic [dcache_pkg::NUM_WAYS-1:0]                         i_way_hit,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::LINE_W-1:0] i_way_line,
    input  logic [dcache_pkg::BYTE_OFFSET_W-1:0]                    i_addr_low,
    input  dcache_pkg::size_t                                       i_size,
    input  logic                                                    i_signed,
    output logic [31:0]                                             o_rdata
);
    import dcache_pkg::*;

    logic [LINE_W-1:0]        hit_line;
    logic [WORD_OFFSET_W-1:0] word_sel;
    logic [31:0]              word;
    logic [7:0]               byte_val;
    logic [15:0]              half_val;

    // hit is one-hot, so an or of the masked lines selects it
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_way_hit[w])
                hit_line = hit_line | i_way_line[w];
        end
    end

    assign word_sel = i_addr_low[BYTE_OFFSET_W-1 -: WORD_OFFSET_W];
    assign word     = hit_line[word_sel*32 +: 32];
    assign byte_val = word[i_addr_low[1:0]*8 +: 8];
    assign half_val = word[i_addr_low[1]*16 +: 16];

    always_comb begin
        case (i_size)
            SIZE_BYTE: o_rdata = {{24{byte_val[7] & i_signed}}, byte_val};
            SIZE_HALF: o_rdata = {{16{half_val[15] & i_signed}}, half_val};
            SIZE_WORD: o_rdata = word;
            default:   o_rdata = 32'd0;   // store or exception response
        endcase
    end

endmodule

// ==== design/dcache_way.sv ====
module dcache_way (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [dcache_pkg::INDEX_W-1:0]    i_rd_index,
    input  logic [dcache_pkg::TAG_W-1:0]      i_tag,
    input  logic [dcache_pkg::INDEX_W-1:0]    i_wr_index,
    input  logic [dcache_pkg::LINE_BYTES-1:0] i_byte_we,
    input  logic [dcache_pkg::LINE_W-1:0]     i_wr_line,
    input  logic                              i_fill,       // new tag, valid set
    input  logic                              i_set_dirty,
    output logic                              o_hit,
    output logic [dcache_pkg::LINE_W-1:0]     o_line,
    output logic [dcache_pkg::TAG_W-1:0]      o_tag,
    output logic                              o_valid,
    output logic                              o_dirty
);
    import dcache_pkg::*;

    logic [LINE_W-1:0]  data_mem [SET_NUM];
    logic [TAG_W-1:0]   tag_mem  [SET_NUM];
    logic [SET_NUM-1:0] valid_bits;
    logic [SET_NUM-1:0] dirty_bits;

    // data and tag arrays
    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_byte_we[b])
                data_mem[i_wr_index][b*8 +: 8] <= i_wr_line[b*8 +: 8];
        end
        if (i_fill)
            tag_mem[i_wr_index] <= i_tag;
        o_line <= data_mem[i_rd_index];   // synchronous read, old data on collision
        o_tag  <= tag_mem[i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            o_valid    <= 1'b0;
            o_dirty    <= 1'b0;
        end else begin
            if (i_fill) begin
                valid_bits[i_wr_index] <= 1'b1;
                dirty_bits[i_wr_index] <= i_set_dirty;   // clean for load refill
            end else if (i_set_dirty) begin
                dirty_bits[i_wr_index] <= 1'b1;
            end
            o_valid <= valid_bits[i_rd_index];
            o_dirty <= dirty_bits[i_rd_index];
        end
    end

    assign o_hit = o_valid && (o_tag == i_tag);

endmodule

// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W        = 32;
    localparam int WORD_OFFSET_W = 2;   // 4 words per line
    localparam int BYTE_OFFSET_W = WORD_OFFSET_W + 2;
    localparam int INDEX_W       = 4;
    localparam int TAG_W         = ADDR_W - INDEX_W - BYTE_OFFSET_W;

    // geometry
    localparam int SET_NUM    = 1 << INDEX_W;
    localparam int LINE_BYTES = 1 << BYTE_OFFSET_W;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int NUM_WAYS   = 2;      // one lru bit per set covers two ways

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,   // tag compare, hit response
        ST_WRITEBACK = 3'd2,   // dirty victim out to memory
        ST_MISS      = 3'd3,   // line read request
        ST_REFILL    = 3'd4,   // victim way overwritten
        ST_RESPOND   = 3'd5    // re-read after refill
    } state_t;

endpackage
